// ==== verilog/host_bus_pkg.sv ====
// host bus package: beat widths, beat numbering and the beat state encoding
package host_bus_pkg;

	localparam int bus_width = 8;
	localparam int beats_per_word = 2; // data beats per memory word

	// one beat on the bus
	typedef logic [bus_width-1:0] bus_byte_t;

	// counts down from the most significant beat
	typedef logic [$clog2(beats_per_word)-1:0] beat_index_t;

	typedef logic [15:0] error_count_t; // address beats that cut a word short

	// beat_done marks a beat on the least significant slot,
	// so the word is complete once enable drops
	typedef enum logic [1:0] {
		beat_idle,
		beat_active,
		beat_done
	} beat_state_t;

endpackage

// ==== verilog/pattern_pkg.sv ====
// pattern package: memory word and address types, write request and player states
package pattern_pkg;

	localparam int word_width = 16;
	localparam int addr_width = 8; // 256 words

	typedef logic [word_width-1:0] word_t;
	typedef logic [addr_width-1:0] word_addr_t;

	// write request from the host side into the memory
	typedef struct packed {
		logic valid; // one cycle per complete word
		word_addr_t addr;
		word_t data;
	} ram_write_t;

	typedef enum logic [1:0] {
		play_stopped,
		play_fetch, // waiting for word 0 from the memory
		play_shift
	} player_state_t;

endpackage

// ==== verilog/host_bus_slave.sv ====
// host bus slave: decodes strobed address and data beats into memory writes and byte reads
module host_bus_slave (
	input logic clock50,
	input logic reset,
	input host_bus_pkg::bus_byte_t bus_in,
	input logic read,
	input logic register_select,
	input logic enable,
	input pattern_pkg::word_t read_data,
	output host_bus_pkg::bus_byte_t bus_out,
	output logic bus_drive,
	output logic ack_valid,
	output pattern_pkg::word_addr_t host_addr,
	output pattern_pkg::ram_write_t write_req,
	output host_bus_pkg::error_count_t protocol_errors
);

	host_bus_pkg::beat_state_t beat_state;
	host_bus_pkg::beat_index_t beat_index;
	host_bus_pkg::beat_index_t top_beat; // most significant slot
	host_bus_pkg::bus_byte_t read_byte;
	pattern_pkg::word_t assembly; // word collected from the data beats
	logic beat_start;
	logic data_beat; // kind of the running beat
	logic write_beat;

	assign top_beat = host_bus_pkg::beat_index_t'(host_bus_pkg::beats_per_word - 1);
	assign beat_start = (beat_state == host_bus_pkg::beat_idle) && enable;
	assign read_byte =
		read_data[int'(beat_index) * host_bus_pkg::bus_width +: host_bus_pkg::bus_width];

	always_ff @(posedge clock50) begin
		if (reset) begin
			beat_state <= host_bus_pkg::beat_idle;
			beat_index <= top_beat;
			ack_valid <= 1'b0;
			host_addr <= '0;
			protocol_errors <= '0;
			data_beat <= 1'b0;
			write_beat <= 1'b0;
		end else begin
			ack_valid <= enable; // one cycle behind every enable cycle
			case (beat_state)
				host_bus_pkg::beat_idle: begin
					if (enable) begin
						data_beat <= read | register_select;
						write_beat <= !read && register_select;
						if (!read && !register_select) begin
							host_addr <= pattern_pkg::word_addr_t'(bus_in);
							beat_index <= top_beat;
							// a half written or half read word is dropped
							if (beat_index != top_beat) begin
								protocol_errors <= protocol_errors + 1'b1;
							end
							beat_state <= host_bus_pkg::beat_active;
						end else if (beat_index == '0) begin
							beat_state <= host_bus_pkg::beat_done; // last slot of the word
						end else begin
							beat_state <= host_bus_pkg::beat_active;
						end
					end
				end
				host_bus_pkg::beat_active: begin
					if (!enable) begin
						if (data_beat) begin
							beat_index <= beat_index - 1'b1; // next lower slot
						end
						beat_state <= host_bus_pkg::beat_idle;
					end
				end
				host_bus_pkg::beat_done: begin
					if (!enable) begin
						beat_index <= top_beat; // back to msb for the next word
						beat_state <= host_bus_pkg::beat_idle;
					end
				end
				default: begin
					beat_state <= host_bus_pkg::beat_idle;
				end
			endcase
		end
	end

	// byte capture on the first enable cycle of a beat
	always_ff @(posedge clock50) begin
		if (beat_start) begin
			if (read) begin
				bus_out <= read_byte;
			end else if (register_select) begin
				assembly[int'(beat_index) * host_bus_pkg::bus_width +: host_bus_pkg::bus_width] <=
					bus_in;
			end
		end
	end

	// the word goes out in the cycle the last write beat drops enable
	always_comb begin
		write_req.valid = (beat_state == host_bus_pkg::beat_done) && !enable && write_beat;
		write_req.addr = host_addr;
		write_req.data = assembly;
	end

	assign bus_drive = ack_valid && read; // only turn the bus around for reads

endmodule

// ==== verilog/word_ram.sv ====
// word ram: 256 x 16 memory with a host write/read port and a playback read port
module word_ram (
	input logic clock50,
	input pattern_pkg::ram_write_t write_req,
	input pattern_pkg::word_addr_t host_addr,
	input pattern_pkg::word_addr_t play_addr,
	output pattern_pkg::word_t host_data,
	output pattern_pkg::word_t play_data
);

	pattern_pkg::word_t mem [2**pattern_pkg::addr_width];

	// write port
	always_ff @(posedge clock50) begin
		if (write_req.valid) begin
			mem[write_req.addr] <= write_req.data;
		end
	end

	// host read port, old data on a same-cycle write
	always_ff @(posedge clock50) begin
		host_data <= mem[host_addr];
	end

	always_ff @(posedge clock50) begin
		play_data <= mem[play_addr]; // playback read port
	end

endmodule

// ==== verilog/pattern_player.sv ====
// pattern player: streams memory words msb first from address 0 to a last address and loops
module pattern_player (
	input logic clock50,
	input logic reset,
	input logic play,
	input pattern_pkg::word_addr_t play_last,
	input pattern_pkg::word_t play_data,
	output pattern_pkg::word_addr_t play_addr,
	output logic serial_out,
	output logic frame_start
);

	pattern_pkg::player_state_t state;
	pattern_pkg::word_t shift_reg;
	logic [$clog2(pattern_pkg::word_width)-1:0] bit_count; // bits left after this one
	logic first_word; // current word opens a loop
	logic next_first; // fetched word opens a loop
	logic load_word;

	assign load_word = (state == pattern_pkg::play_fetch) ||
		((state == pattern_pkg::play_shift) && (bit_count == '0));

	always_ff @(posedge clock50) begin
		if (reset) begin
			state <= pattern_pkg::play_stopped;
			play_addr <= '0;
			bit_count <= '0;
			first_word <= 1'b0;
			next_first <= 1'b0;
		end else if (!play) begin
			state <= pattern_pkg::play_stopped;
			play_addr <= '0; // word 0 sits on the read port for the restart
			first_word <= 1'b0;
		end else begin
			case (state)
				pattern_pkg::play_stopped: begin
					state <= pattern_pkg::play_fetch;
				end
				pattern_pkg::play_fetch: begin
					bit_count <= '1; // word_width is a power of two
					first_word <= 1'b1;
					state <= pattern_pkg::play_shift;
				end
				pattern_pkg::play_shift: begin
					// next address two bits early, covers the read latency
					if (bit_count == 2) begin
						next_first <= (play_addr == play_last);
						play_addr <= (play_addr == play_last) ? '0 : play_addr + 1'b1;
					end
					if (bit_count == '0) begin
						bit_count <= '1;
						first_word <= next_first;
					end else begin
						bit_count <= bit_count - 1'b1;
					end
				end
				default: begin
					state <= pattern_pkg::play_stopped;
				end
			endcase
		end
	end

	always_ff @(posedge clock50) begin
		if (load_word) begin
			shift_reg <= play_data;
		end else begin
			shift_reg <= shift_reg << 1; // msb first
		end
	end

	assign serial_out = play && (state == pattern_pkg::play_shift) &&
		shift_reg[pattern_pkg::word_width-1];
	assign frame_start = play && (state == pattern_pkg::play_shift) && first_word &&
		(bit_count == '1);

endmodule

// ==== verilog/pattern_top.sv ====
// pattern memory top: host bus slave, two-port word memory and serial pattern player
module pattern_top (
	input logic clock50,
	input logic reset,
	input host_bus_pkg::bus_byte_t bus_in,
	input logic read,
	input logic register_select, // 0 address, 1 data
	input logic enable,
	input logic play,
	input pattern_pkg::word_addr_t play_last,
	output host_bus_pkg::bus_byte_t bus_out,
	output logic bus_drive,
	output logic ack_valid,
	output host_bus_pkg::error_count_t protocol_errors,
	output logic serial_out,
	output logic frame_start
);

	pattern_pkg::word_addr_t host_addr;
	pattern_pkg::word_addr_t play_addr;
	pattern_pkg::ram_write_t write_req;
	pattern_pkg::word_t host_data;
	pattern_pkg::word_t play_data;

	host_bus_slave host_bus_slave_i (
		.clock50(clock50),
		.reset(reset),
		.bus_in(bus_in),
		.read(read),
		.register_select(register_select),
		.enable(enable),
		.read_data(host_data),
		.bus_out(bus_out),
		.bus_drive(bus_drive),
		.ack_valid(ack_valid),
		.host_addr(host_addr),
		.write_req(write_req),
		.protocol_errors(protocol_errors)
	);

	word_ram word_ram_i (
		.clock50(clock50),
		.write_req(write_req),
		.host_addr(host_addr),
		.play_addr(play_addr),
		.host_data(host_data),
		.play_data(play_data)
	);

	pattern_player pattern_player_i (
		.clock50(clock50),
		.reset(reset),
		.play(play),
		.play_last(play_last),
		.play_data(play_data),
		.play_addr(play_addr),
		.serial_out(serial_out),
		.frame_start(frame_start)
	);

endmodule

// ==== tb/pattern_tb.sv ====
// pattern memory testbench: host bus beats, read back, protocol errors and serial playback
module pattern_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int word_count = 40; // random words in the read back test
	localparam pattern_pkg::word_addr_t play_last_value = 5;
	localparam int loop_bits = (play_last_value + 1) * pattern_pkg::word_width;
	localparam int beat_count = word_count * 3 * 2 + 16 + (play_last_value + 1) * 3;
	localparam int play_cycles = loop_bits * 4 + 100;
	localparam int watchdog_ns = (beat_count * 6 + play_cycles + 1000) * 10;

	logic clock50 = 1'b0;
	logic reset;
	host_bus_pkg::bus_byte_t bus_in;
	logic read;
	logic register_select;
	logic enable;
	logic play;
	pattern_pkg::word_addr_t play_last;
	host_bus_pkg::bus_byte_t bus_out;
	logic bus_drive;
	logic ack_valid;
	host_bus_pkg::error_count_t protocol_errors;
	logic serial_out;
	logic frame_start;

	pattern_pkg::word_t model [256]; // expected memory contents
	pattern_pkg::word_addr_t addrs [word_count];
	bit used [256];
	host_bus_pkg::error_count_t exp_errors = '0;
	int errors = 0;
	int checks = 0;
	logic checking = 1'b0;
	logic last_enable = 1'b0;
	logic streaming = 1'b0; // set by the first frame_start after play rises
	int stream_pos = 0;

	always #5 clock50 = ~clock50;

	pattern_top pattern_top_i (
		.clock50(clock50),
		.reset(reset),
		.bus_in(bus_in),
		.read(read),
		.register_select(register_select),
		.enable(enable),
		.play(play),
		.play_last(play_last),
		.bus_out(bus_out),
		.bus_drive(bus_drive),
		.ack_valid(ack_valid),
		.protocol_errors(protocol_errors),
		.serial_out(serial_out),
		.frame_start(frame_start)
	);

	task automatic check_byte(input string name, input host_bus_pkg::bus_byte_t expected,
		input host_bus_pkg::bus_byte_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic check_errors(input string name, input host_bus_pkg::error_count_t expected,
		input host_bus_pkg::error_count_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAIL %0t %s expected %0d actual %0d", $time, name, expected, actual);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAIL %0t %s expected %b actual %b", $time, name, expected, actual);
		end
	endtask

	// bit at a stream position, msb of word 0 is position 0
	function automatic logic ref_bit(input int pos);
		int word_index;
		pattern_pkg::word_t shifted;
		word_index = (pos / pattern_pkg::word_width) % (int'(play_last_value) + 1);
		shifted = model[pattern_pkg::word_addr_t'(word_index)] << (pos % pattern_pkg::word_width);
		return shifted[pattern_pkg::word_width-1];
	endfunction

	// one beat, called on a falling edge
	task automatic run_beat(input logic sel, input logic rd, input host_bus_pkg::bus_byte_t value);
		int high_cycles;
		int low_cycles;
		high_cycles = $urandom_range(3, 1);
		low_cycles = $urandom_range(2, 1);
		register_select = sel;
		read = rd;
		bus_in = value;
		enable = 1'b1;
		repeat (high_cycles) @(negedge clock50);
		enable = 1'b0;
		repeat (low_cycles) @(negedge clock50);
	endtask

	task automatic address_beat(input pattern_pkg::word_addr_t addr);
		run_beat(1'b0, 1'b0, host_bus_pkg::bus_byte_t'(addr));
	endtask

	task automatic write_word(input pattern_pkg::word_addr_t addr, input pattern_pkg::word_t data);
		address_beat(addr);
		run_beat(1'b1, 1'b0, host_bus_pkg::bus_byte_t'(data >> host_bus_pkg::bus_width));
		run_beat(1'b1, 1'b0, host_bus_pkg::bus_byte_t'(data)); // low byte last
		model[addr] = data;
	endtask

	task automatic read_word(input pattern_pkg::word_addr_t addr);
		address_beat(addr);
		run_beat(1'b1, 1'b1, '0);
		check_byte("bus_out", host_bus_pkg::bus_byte_t'(model[addr] >> host_bus_pkg::bus_width),
			bus_out);
		run_beat(1'b1, 1'b1, '0);
		check_byte("bus_out", host_bus_pkg::bus_byte_t'(model[addr]), bus_out);
	endtask

	// values seen at a rising edge belong to the cycle that just ended
	always @(posedge clock50) begin
		if (checking) begin
			check_bit("ack_valid", last_enable, ack_valid);
			check_bit("bus_drive", last_enable && read, bus_drive);
			if (!play) begin
				streaming = 1'b0;
				stream_pos = 0;
				check_bit("serial_out", 1'b0, serial_out);
				check_bit("frame_start", 1'b0, frame_start);
			end else begin
				if (!streaming && frame_start) begin
					streaming = 1'b1;
					stream_pos = 0;
				end
				if (streaming) begin
					check_bit("serial_out", ref_bit(stream_pos), serial_out);
					check_bit("frame_start", (stream_pos % loop_bits) == 0, frame_start);
					stream_pos++;
				end else begin
					check_bit("serial_out", 1'b0, serial_out); // still fetching word 0
				end
			end
		end
		last_enable = enable;
	end

	initial begin
		#(watchdog_ns);
		$display("run timed out after %0d ns without finishing the tests", watchdog_ns);
		$display("%0d errors in %0d checks", errors, checks);
		$display("Test FAILED");
		$finish;
	end

	initial begin
		pattern_pkg::word_addr_t a;
		void'($urandom(32'he360));
		reset = 1'b1;
		bus_in = '0;
		read = 1'b0;
		register_select = 1'b0;
		enable = 1'b0;
		play = 1'b0;
		play_last = play_last_value;
		repeat (10) @(negedge clock50);
		reset = 1'b0;
		checking = 1'b1;
		@(negedge clock50);
		check_bit("ack_valid", 1'b0, ack_valid);
		check_bit("bus_drive", 1'b0, bus_drive);
		check_bit("serial_out", 1'b0, serial_out);
		check_bit("frame_start", 1'b0, frame_start);
		check_errors("protocol_errors", '0, protocol_errors);

		for (int i = 0; i < word_count; i++) begin
			do begin
				a = pattern_pkg::word_addr_t'($urandom);
			end while (used[a]);
			used[a] = 1'b1;
			addrs[i] = a;
			write_word(a, pattern_pkg::word_t'($urandom));
		end
		for (int i = word_count - 1; i >= 0; i--) begin
			read_word(addrs[i]); // reverse of the write order
		end
		check_errors("protocol_errors", exp_errors, protocol_errors);

		// write cut short by an address beat
		a = addrs[0];
		address_beat(a);
		run_beat(1'b1, 1'b0, ~host_bus_pkg::bus_byte_t'(model[a] >> host_bus_pkg::bus_width));
		address_beat(a);
		exp_errors++;
		check_errors("protocol_errors", exp_errors, protocol_errors);
		read_word(a); // previous word survives
		check_errors("protocol_errors", exp_errors, protocol_errors);
		// read cut short
		address_beat(a);
		run_beat(1'b1, 1'b1, '0);
		check_byte("bus_out", host_bus_pkg::bus_byte_t'(model[a] >> host_bus_pkg::bus_width),
			bus_out);
		address_beat(a);
		exp_errors++;
		check_errors("protocol_errors", exp_errors, protocol_errors);

		for (int i = 0; i <= int'(play_last_value); i++) begin
			write_word(pattern_pkg::word_addr_t'(i), pattern_pkg::word_t'($urandom));
		end
		play = 1'b1;
		while (!(streaming && stream_pos >= 3 * loop_bits)) @(negedge clock50);
		play = 1'b0;
		repeat (20) @(negedge clock50); // output must stay quiet
		play = 1'b1;
		while (!(streaming && stream_pos >= loop_bits)) @(negedge clock50);
		play = 1'b0;
		repeat (5) @(negedge clock50);

		$display("%0d errors in %0d checks", errors, checks);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== build.f ====
verilog/host_bus_pkg.sv
verilog/pattern_pkg.sv
verilog/host_bus_slave.sv
verilog/word_ram.sv
verilog/pattern_player.sv
verilog/pattern_top.sv
tb/pattern_tb.sv

// ==== Makefile ====
# verilator flow for the pattern memory: lint, simulate, clean

VERILATOR ?= verilator
TOP ?= pattern_tb
RTL_TOP ?= pattern_top
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing
PASS_TEXT ?= Test OK

SRCS := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(filter verilog/%,$(SRCS))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(OBJ_DIR)
